// ==== verilog/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

        // line geometry
        localparam int OFFSET_W = 4;
        localparam int WORD_W   = 32;
        localparam int BANKS    = 4;
        localparam int WAYS     = 2;

        typedef logic [1:0]              bank_sel_t;
        typedef logic [WORD_W-1:0]       word_t;
        typedef logic [WORD_W/8-1:0]     strb_t;
        typedef logic [BANKS*WORD_W-1:0] line_t;

endpackage

// ==== verilog/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

        // one-hot main states
        typedef enum logic [4:0] {
                IDLE    = 5'b00001,
                LOOKUP  = 5'b00010,
                MISS    = 5'b00100,
                REPLACE = 5'b01000,
                REFILL  = 5'b10000
        } cache_state_t;

        typedef enum logic [1:0] {
                WBUF_IDLE  = 2'b01,
                WBUF_WRITE = 2'b10
        } wbuf_state_t;

endpackage

// ==== verilog/cache_req_if.sv ====
`timescale 1ns/1ps

interface cache_req_if #(
        parameter int INDEX_W = 8
);
        import cache_cfg_pkg::*;

        localparam int TAG_W = 32 - INDEX_W - OFFSET_W;

        // registered cpu request
        logic               req_op;
        logic [INDEX_W-1:0] req_index;
        logic [TAG_W-1:0]   req_tag;
        bank_sel_t          req_bank;
        strb_t              req_wstrb;
        word_t              req_wdata;
        // lookup, refill and buffer controls
        logic               lookup_rd;
        logic               fill_beat;
        logic               fill_target;
        logic               wbuf_write;
        logic               victim_way;

        modport ctrl (
                output req_op, req_index, req_tag, req_bank, req_wstrb, req_wdata,
                output lookup_rd, fill_beat, fill_target, wbuf_write, victim_way
        );
        modport tags (
                input req_op, req_index, req_tag, lookup_rd, fill_target, wbuf_write,
                input victim_way
        );
        modport data (
                input req_op, req_index, req_bank, req_wstrb, req_wdata,
                input lookup_rd, fill_beat, fill_target, wbuf_write, victim_way
        );

endinterface

// ==== verilog/sp_ram.sv ====
`timescale 1ns/1ps

module sp_ram #(
        parameter type payload_t = logic [31:0],
        parameter int  INDEX_W   = 8
) (
        input  logic               clk,
        input  logic               en,
        input  logic               we,
        input  logic [INDEX_W-1:0] addr,
        input  payload_t           din,
        output payload_t           dout
);
        payload_t mem [2**INDEX_W];

        // read returns the old entry on a write cycle
        always_ff @(posedge clk) begin
                if (en) begin
                        if (we) begin
                                mem[addr] <= din;
                        end
                        dout <= mem[addr];
                end
        end

endmodule

// ==== verilog/refill_beat_counter.sv ====
`timescale 1ns/1ps

module refill_beat_counter (
        input  logic                     clk,
        input  logic                     resetn,
        input  logic                     ret_valid,
        input  logic                     ret_last,
        input  cache_cfg_pkg::bank_sel_t target_bank,
        output cache_cfg_pkg::bank_sel_t beat,
        output logic                     beat_target
);

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        beat <= '0;
                end else if (ret_valid) begin
                        if (ret_last) begin
                                beat <= '0;
                        end else begin
                                beat <= beat + 1'b1;
                        end
                end
        end

        // beat carrying the requested word
        assign beat_target = ret_valid && (beat == target_bank);

endmodule

// ==== verilog/cache_fsm.sv ====
`timescale 1ns/1ps

module cache_fsm #(
        parameter int INDEX_W = 8
) (
        input  logic                                          clk,
        input  logic                                          resetn,
        input  logic                                          valid,
        input  logic                                          op,
        input  logic [INDEX_W-1:0]                            index,
        input  logic [31-INDEX_W-cache_cfg_pkg::OFFSET_W:0]   tag,
        input  logic [cache_cfg_pkg::OFFSET_W-1:0]            offset,
        input  cache_cfg_pkg::strb_t                          wstrb,
        input  cache_cfg_pkg::word_t                          wdata,
        input  logic                                          hit,
        input  logic                                          victim_dirty,
        input  logic                                          victim,
        input  logic                                          beat_target,
        input  logic                                          rd_rdy,
        input  logic                                          wr_rdy,
        input  logic                                          ret_valid,
        input  logic                                          ret_last,
        output logic                                          addr_ok,
        output logic                                          data_ok,
        output logic                                          rd_req,
        output logic                                          wr_req,
        output logic [31:0]                                   rd_addr,
        cache_req_if.ctrl                                     req
);
        import cache_cfg_pkg::*;
        import cache_ctrl_pkg::*;

        cache_state_t state;
        cache_state_t state_nxt;
        wbuf_state_t  wbuf;
        wbuf_state_t  wbuf_nxt;
        logic         accept;

        assign addr_ok = (state == IDLE) && (wbuf == WBUF_IDLE);
        assign accept  = valid && addr_ok;

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        state <= IDLE;
                        wbuf  <= WBUF_IDLE;
                end else begin
                        state <= state_nxt;
                        wbuf  <= wbuf_nxt;
                end
        end

        always_comb begin
                state_nxt = state;
                case (state)
                IDLE:
                        if (accept)
                                state_nxt = LOOKUP;
                LOOKUP:
                        if (hit)
                                state_nxt = IDLE;
                        else
                                state_nxt = MISS;
                MISS:
                        if (!victim_dirty || wr_rdy)
                                state_nxt = REPLACE;
                REPLACE:
                        if (rd_rdy)
                                state_nxt = REFILL;
                REFILL:
                        if (ret_valid && ret_last)
                                state_nxt = IDLE;
                default:
                        state_nxt = IDLE;
                endcase
        end

        // store hit gets written back in the following cycle
        always_comb begin
                if (state == LOOKUP && hit && req.req_op)
                        wbuf_nxt = WBUF_WRITE;
                else
                        wbuf_nxt = WBUF_IDLE;
        end

        always_ff @(posedge clk) begin
                if (accept) begin
                        req.req_op    <= op;
                        req.req_index <= index;
                        req.req_tag   <= tag;
                        req.req_bank  <= offset[OFFSET_W-1:2];
                        req.req_wstrb <= wstrb;
                        req.req_wdata <= wdata;
                end
                // held until the refill is done
                if (state == LOOKUP) begin
                        req.victim_way <= victim;
                end
        end

        assign req.lookup_rd   = accept;
        assign req.fill_beat   = (state == REFILL) && ret_valid;
        assign req.fill_target = (state == REFILL) && beat_target;
        assign req.wbuf_write  = (wbuf == WBUF_WRITE);

        assign data_ok = (state == LOOKUP) && (hit || req.req_op) ||
                         (state == REFILL) && beat_target && !req.req_op;
        assign rd_req  = (state == REPLACE);
        assign wr_req  = (state == MISS) && victim_dirty;
        assign rd_addr = {req.req_tag, req.req_index, {OFFSET_W{1'b0}}};

endmodule

// ==== verilog/tag_store.sv ====
`timescale 1ns/1ps

module tag_store #(
        parameter int INDEX_W = 8
) (
        input  logic               clk,
        input  logic               resetn,
        input  logic [INDEX_W-1:0] index,
        cache_req_if.tags          req,
        output logic               hit,
        output logic               hit_way,
        output logic               victim_dirty,
        output logic               victim,
        output logic [31:0]        wr_addr
);
        import cache_cfg_pkg::*;

        localparam int TAG_W = 32 - INDEX_W - OFFSET_W;
        localparam int SETS  = 2**INDEX_W;

        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic             valid;
        } tag_entry_t;

        tag_entry_t      entry [WAYS];
        tag_entry_t      new_entry;
        logic [SETS-1:0] filled [WAYS];
        logic [SETS-1:0] dirty [WAYS];
        logic [SETS-1:0] rr;
        logic [WAYS-1:0] filled_q;
        logic [WAYS-1:0] line_vld;
        logic [WAYS-1:0] way_hit;

        assign new_entry = '{tag: req.req_tag, valid: 1'b1};

        for (genvar w = 0; w < WAYS; w++) begin : g_way
                sp_ram #(
                        .payload_t (tag_entry_t),
                        .INDEX_W   (INDEX_W)
                ) i_tag_ram (
                        .clk  (clk),
                        .en   (req.lookup_rd || req.fill_target && req.victim_way == 1'(w)),
                        .we   (req.fill_target),
                        .addr (req.lookup_rd ? index : req.req_index),
                        .din  (new_entry),
                        .dout (entry[w])
                );
                // ram content only counts once the set was filled since reset
                assign line_vld[w] = entry[w].valid && filled_q[w];
                assign way_hit[w]  = line_vld[w] && (entry[w].tag == req.req_tag);
        end

        always_ff @(posedge clk) begin
                if (req.lookup_rd) begin
                        for (int w = 0; w < WAYS; w++) begin
                                filled_q[w] <= filled[w][index];
                        end
                end
        end

        assign hit     = |way_hit;
        assign hit_way = way_hit[1];

        // free way first, then round robin
        assign victim = !line_vld[0] ? 1'b0 :
                        !line_vld[1] ? 1'b1 : rr[req.req_index];
        assign victim_dirty = line_vld[victim] && dirty[victim][req.req_index];
        assign wr_addr      = {entry[victim].tag, req.req_index, {OFFSET_W{1'b0}}};

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        for (int w = 0; w < WAYS; w++) begin
                                filled[w] <= '0;
                                dirty[w]  <= '0;
                        end
                        rr <= '0;
                end else if (req.wbuf_write) begin
                        dirty[hit_way][req.req_index] <= 1'b1;
                end else if (req.fill_target) begin
                        filled[req.victim_way][req.req_index] <= 1'b1;
                        dirty[req.victim_way][req.req_index]  <= req.req_op;
                        rr[req.req_index]                     <= ~req.victim_way;
                end
        end

endmodule

// ==== verilog/data_store.sv ====
`timescale 1ns/1ps

module data_store #(
        parameter int INDEX_W = 8
) (
        input  logic                     clk,
        input  logic                     resetn,
        input  logic [INDEX_W-1:0]       index,
        input  logic                     hit_way,
        input  cache_cfg_pkg::bank_sel_t beat,
        input  cache_cfg_pkg::word_t     ret_data,
        cache_req_if.data                req,
        output cache_cfg_pkg::word_t     rdata,
        output cache_cfg_pkg::line_t     wr_data
);
        import cache_cfg_pkg::*;

        word_t bank_q [WAYS][BANKS];
        word_t load_word;
        word_t fill_word;
        word_t wbuf_data;
        logic  wbuf_way;

        function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
                word_t res;
                for (int i = 0; i < WORD_W/8; i++) begin
                        res[8*i +: 8] = strb[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
                end
                return res;
        endfunction

        for (genvar w = 0; w < WAYS; w++) begin : g_way
                for (genvar b = 0; b < BANKS; b++) begin : g_bank
                        logic fill_we;
                        logic wbuf_we;

                        assign fill_we = req.fill_beat && req.victim_way == 1'(w) &&
                                         beat == bank_sel_t'(b);
                        assign wbuf_we = req.wbuf_write && wbuf_way == 1'(w) &&
                                         req.req_bank == bank_sel_t'(b);

                        sp_ram #(
                                .payload_t (word_t),
                                .INDEX_W   (INDEX_W)
                        ) i_data_ram (
                                .clk  (clk),
                                .en   (req.lookup_rd || fill_we || wbuf_we),
                                .we   (fill_we || wbuf_we),
                                .addr (req.lookup_rd ? index : req.req_index),
                                .din  (req.wbuf_write ? wbuf_data : fill_word),
                                .dout (bank_q[w][b])
                        );
                end
        end

        assign load_word = bank_q[hit_way][req.req_bank];

        // hit-write buffer holds the merged word
        always_ff @(posedge clk) begin
                if (!resetn) begin
                        wbuf_way  <= 1'b0;
                        wbuf_data <= '0;
                end else if (!req.wbuf_write) begin
                        wbuf_way  <= hit_way;
                        wbuf_data <= merge_bytes(load_word, req.req_wdata, req.req_wstrb);
                end
        end

        // store miss lands its bytes on the target beat
        assign fill_word = (req.fill_target && req.req_op) ?
                           merge_bytes(ret_data, req.req_wdata, req.req_wstrb) : ret_data;

        assign rdata = req.fill_target ? ret_data : load_word;

        always_comb begin
                for (int b = 0; b < BANKS; b++) begin
                        wr_data[b*WORD_W +: WORD_W] = bank_q[req.victim_way][b];
                end
        end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
        parameter int INDEX_W = 8
) (
        input  logic                                        clk,
        input  logic                                        resetn,
        input  logic                                        valid,
        input  logic                                        op,
        input  logic [INDEX_W-1:0]                          index,
        input  logic [31-INDEX_W-cache_cfg_pkg::OFFSET_W:0] tag,
        input  logic [cache_cfg_pkg::OFFSET_W-1:0]          offset,
        input  cache_cfg_pkg::strb_t                        wstrb,
        input  cache_cfg_pkg::word_t                        wdata,
        output logic                                        addr_ok,
        output logic                                        data_ok,
        output cache_cfg_pkg::word_t                        rdata,
        output logic                                        rd_req,
        output logic [31:0]                                 rd_addr,
        input  logic                                        rd_rdy,
        input  logic                                        ret_valid,
        input  logic                                        ret_last,
        input  cache_cfg_pkg::word_t                        ret_data,
        output logic                                        wr_req,
        output logic [31:0]                                 wr_addr,
        output cache_cfg_pkg::line_t                        wr_data,
        input  logic                                        wr_rdy
);
        import cache_cfg_pkg::*;

        logic      hit;
        logic      hit_way;
        logic      victim_dirty;
        logic      victim;
        logic      beat_target;
        bank_sel_t beat;

        cache_req_if #(.INDEX_W(INDEX_W)) req_bus ();

        cache_fsm #(.INDEX_W(INDEX_W)) i_cache_fsm (
                .clk          (clk),
                .resetn       (resetn),
                .valid        (valid),
                .op           (op),
                .index        (index),
                .tag          (tag),
                .offset       (offset),
                .wstrb        (wstrb),
                .wdata        (wdata),
                .hit          (hit),
                .victim_dirty (victim_dirty),
                .victim       (victim),
                .beat_target  (beat_target),
                .rd_rdy       (rd_rdy),
                .wr_rdy       (wr_rdy),
                .ret_valid    (ret_valid),
                .ret_last     (ret_last),
                .addr_ok      (addr_ok),
                .data_ok      (data_ok),
                .rd_req       (rd_req),
                .wr_req       (wr_req),
                .rd_addr      (rd_addr),
                .req          (req_bus.ctrl)
        );

        refill_beat_counter i_beat_cnt (
                .clk         (clk),
                .resetn      (resetn),
                .ret_valid   (ret_valid),
                .ret_last    (ret_last),
                .target_bank (req_bus.req_bank),
                .beat        (beat),
                .beat_target (beat_target)
        );

        tag_store #(.INDEX_W(INDEX_W)) i_tag_store (
                .clk          (clk),
                .resetn       (resetn),
                .index        (index),
                .req          (req_bus.tags),
                .hit          (hit),
                .hit_way      (hit_way),
                .victim_dirty (victim_dirty),
                .victim       (victim),
                .wr_addr      (wr_addr)
        );

        data_store #(.INDEX_W(INDEX_W)) i_data_store (
                .clk      (clk),
                .resetn   (resetn),
                .index    (index),
                .hit_way  (hit_way),
                .beat     (beat),
                .ret_data (ret_data),
                .req      (req_bus.data),
                .rdata    (rdata),
                .wr_data  (wr_data)
        );

endmodule

// ==== tb/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache;
        import cache_cfg_pkg::*;

        localparam int INDEX_W      = 8;
        localparam int TAG_W        = 32 - INDEX_W - OFFSET_W;
        localparam int N_DIRECTED   = 12;
        localparam int N_RANDOM     = 300;
        // accept, lookup, stalled write-back, stalled read, four beats
        localparam int ACCESS_MAX   = 40;
        localparam int CYCLE_LIMIT  = (N_DIRECTED + N_RANDOM) * ACCESS_MAX + 20;
        localparam logic [31:0] ADDR_A  = 32'h0123_4218;
        localparam logic [31:0] ADDR_B  = 32'h00ab_c3a4;
        localparam logic [31:0] EV_T0   = 32'h1111_15c8;
        localparam logic [31:0] EV_T1   = 32'h2222_25c0;
        localparam logic [31:0] EV_T2   = 32'h3333_35c4;

        logic               clk       = 1'b0;
        logic               resetn    = 1'b0;
        logic               valid     = 1'b0;
        logic               op        = 1'b0;
        logic [INDEX_W-1:0] index     = '0;
        logic [TAG_W-1:0]   tag       = '0;
        logic [OFFSET_W-1:0] offset   = '0;
        strb_t              wstrb     = '0;
        word_t              wdata     = '0;
        logic               rd_rdy    = 1'b0;
        logic               ret_valid = 1'b0;
        logic               ret_last  = 1'b0;
        word_t              ret_data  = '0;
        logic               wr_rdy    = 1'b0;
        logic               addr_ok;
        logic               data_ok;
        word_t              rdata;
        logic               rd_req;
        logic [31:0]        rd_addr;
        logic               wr_req;
        logic [31:0]        wr_addr;
        line_t              wr_data;

        // bridge model state
        word_t               backing [logic [29:0]];
        word_t               shadow [logic [29:0]];
        logic                rd_fire    = 1'b0;
        logic                wr_fire    = 1'b0;
        logic                rd_rdy_nxt = 1'b0;
        logic                wr_rdy_nxt = 1'b0;
        logic [31:0]         rd_base    = '0;
        logic [31:0]         wb_addr    = '0;
        logic [31:0]         last_wb    = '0;
        line_t               wb_line    = '0;
        logic [31:OFFSET_W]  ret_line   = '0;
        logic [1:0]          ret_cnt    = '0;
        logic                ret_busy   = 1'b0;
        int                  wb_count   = 0;
        int                  cycle_cnt  = 0;
        logic [31:0]         lfsr       = 32'h254e;
        logic [TAG_W-1:0]    tag_pool [3]   = '{20'h00a17, 20'h5c3e0, 20'hfff21};
        logic [INDEX_W-1:0]  index_pool [4] = '{8'h00, 8'h3d, 8'h80, 8'hff};

        cache_top #(.INDEX_W(INDEX_W)) i_cache_top (
                .clk       (clk),
                .resetn    (resetn),
                .valid     (valid),
                .op        (op),
                .index     (index),
                .tag       (tag),
                .offset    (offset),
                .wstrb     (wstrb),
                .wdata     (wdata),
                .addr_ok   (addr_ok),
                .data_ok   (data_ok),
                .rdata     (rdata),
                .rd_req    (rd_req),
                .rd_addr   (rd_addr),
                .rd_rdy    (rd_rdy),
                .ret_valid (ret_valid),
                .ret_last  (ret_last),
                .ret_data  (ret_data),
                .wr_req    (wr_req),
                .wr_addr   (wr_addr),
                .wr_data   (wr_data),
                .wr_rdy    (wr_rdy)
        );

        initial begin
                forever #50 clk = ~clk;
        end

        task automatic stop_on_error(input string line);
                $display("%s", line);
                $display("Test failed");
                $fatal(1, "simulation stopped on error");
        endtask

        // galois form of x^32 + x^22 + x^2 + x + 1
        function automatic logic lfsr_bit();
                logic out;
                out  = lfsr[0];
                lfsr = lfsr >> 1;
                if (out)
                        lfsr = lfsr ^ 32'h8020_0003;
                return out;
        endfunction

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++)
                        v = {v[30:0], lfsr_bit()};
                return v;
        endfunction

        // content of a word that was never written
        function automatic word_t pattern_word(input logic [29:0] waddr);
                return {waddr, 2'b11} ^ {waddr[14:0], waddr[29:13]} ^ 32'h6b3c_91e5;
        endfunction

        function automatic word_t backing_word(input logic [29:0] waddr);
                return backing.exists(waddr) ? backing[waddr] : pattern_word(waddr);
        endfunction

        function automatic word_t shadow_word(input logic [29:0] waddr);
                return shadow.exists(waddr) ? shadow[waddr] : pattern_word(waddr);
        endfunction

        function automatic word_t apply_strobe(word_t old_w, word_t new_w, strb_t strb);
                word_t res;
                for (int i = 0; i < 4; i++)
                        res[8*i +: 8] = strb[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
                return res;
        endfunction

        // starts and ends on a rising edge
        // lat is the number of cycles from accept to data_ok
        task automatic cpu_access(input logic wr, input logic [31:0] addr, input strb_t strb,
                                  input word_t data, output int lat);
                word_t expected;
                valid  <= 1'b1;
                op     <= wr;
                tag    <= addr[31 -: TAG_W];
                index  <= addr[OFFSET_W +: INDEX_W];
                offset <= addr[OFFSET_W-1:0];
                wstrb  <= strb;
                wdata  <= data;
                @(negedge clk);
                while (!addr_ok)
                        @(negedge clk);
                @(posedge clk);
                valid <= 1'b0;
                if (wr)
                        shadow[addr[31:2]] = apply_strobe(shadow_word(addr[31:2]), data, strb);
                expected = shadow_word(addr[31:2]);
                @(negedge clk);
                lat = 1;
                while (!data_ok) begin
                        @(negedge clk);
                        lat = lat + 1;
                end
                if (!wr) begin
                        assert (rdata == expected)
                        else stop_on_error($sformatf(
                                "MISMATCH at %0t: load %08h got %08h, expected %08h",
                                $time, addr, rdata, expected));
                end
                @(posedge clk);
        endtask

        // bridge sampling and write-back checks
        always @(negedge clk) begin
                rd_rdy_nxt = lfsr_bit() | lfsr_bit();
                wr_rdy_nxt = lfsr_bit() | lfsr_bit();
                rd_fire    = resetn && rd_req && rd_rdy;
                wr_fire    = resetn && wr_req && wr_rdy;
                rd_base    = rd_addr;
                wb_addr    = wr_addr;
                wb_line    = wr_data;
                if (resetn && rd_req) begin
                        assert (rd_addr[OFFSET_W-1:0] == '0)
                        else stop_on_error($sformatf("MISMATCH at %0t: rd_addr %08h unaligned",
                                                     $time, rd_addr));
                end
                if (wr_fire) begin
                        wb_count = wb_count + 1;
                        last_wb  = wr_addr;
                        assert (wr_addr[OFFSET_W-1:0] == '0)
                        else stop_on_error($sformatf("MISMATCH at %0t: wr_addr %08h unaligned",
                                                     $time, wr_addr));
                        for (int b = 0; b < BANKS; b++) begin
                                assert (wr_data[b*WORD_W +: WORD_W] ==
                                        shadow_word({wr_addr[31:4], 2'(b)}))
                                else stop_on_error($sformatf(
                                        "MISMATCH at %0t: line %08h word %0d is %08h, not %08h",
                                        $time, wr_addr, b, wr_data[b*WORD_W +: WORD_W],
                                        shadow_word({wr_addr[31:4], 2'(b)})));
                        end
                end
        end

        // bridge responses with beats right after the accepted read
        always @(posedge clk) begin
                rd_rdy <= rd_rdy_nxt;
                wr_rdy <= wr_rdy_nxt;
                if (wr_fire) begin
                        for (int b = 0; b < BANKS; b++)
                                backing[{wb_addr[31:4], 2'(b)}] = wb_line[b*WORD_W +: WORD_W];
                end
                if (rd_fire) begin
                        ret_line = rd_base[31:OFFSET_W];
                        ret_cnt  = 2'd0;
                        ret_busy = 1'b1;
                end
                if (ret_busy) begin
                        ret_valid <= 1'b1;
                        ret_last  <= (ret_cnt == 2'd3);
                        ret_data  <= backing_word({ret_line, ret_cnt});
                        if (ret_cnt == 2'd3)
                                ret_busy = 1'b0;
                        ret_cnt = ret_cnt + 2'd1;
                end else begin
                        ret_valid <= 1'b0;
                        ret_last  <= 1'b0;
                end
        end

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_cnt >= CYCLE_LIMIT)
                        stop_on_error($sformatf("timeout: cache did not finish within %0d cycles",
                                                CYCLE_LIMIT));
        end

        initial begin : stimulus
                logic        wr;
                logic [31:0] addr;
                logic [31:0] bits;
                strb_t       strb;
                int          ti;
                int          ii;
                int          lat;
                int          wb_before;

                repeat (10) @(posedge clk);
                resetn <= 1'b1;
                @(negedge clk);
                assert (addr_ok && !rd_req && !wr_req && !data_ok)
                else stop_on_error($sformatf("MISMATCH at %0t: outputs after reset %b%b%b%b",
                                             $time, addr_ok, rd_req, wr_req, data_ok));
                @(posedge clk);

                // cold read, then the same word again as a hit
                cpu_access(1'b0, ADDR_A, 4'h0, 32'h0, lat);
                cpu_access(1'b0, ADDR_A, 4'h0, 32'h0, lat);
                assert (lat == 1)
                else stop_on_error($sformatf("MISMATCH at %0t: hit read data_ok after %0d cycles",
                                             $time, lat));

                // store hit and store miss
                cpu_access(1'b1, ADDR_A, 4'b0110, 32'hcafe_f00d, lat);
                cpu_access(1'b0, ADDR_A, 4'h0, 32'h0, lat);
                cpu_access(1'b1, ADDR_B, 4'b1001, 32'h1357_9bdf, lat);
                cpu_access(1'b0, ADDR_B, 4'h0, 32'h0, lat);
                cpu_access(1'b0, ADDR_B ^ 32'h4, 4'h0, 32'h0, lat);

                // three tags on one set evict the dirty first line
                cpu_access(1'b1, EV_T0, 4'b1110, 32'h8899_aabb, lat);
                cpu_access(1'b0, EV_T1, 4'h0, 32'h0, lat);
                wb_before = wb_count;
                cpu_access(1'b0, EV_T2, 4'h0, 32'h0, lat);
                assert (wb_count != wb_before)
                else stop_on_error("dirty line was not written back on eviction");
                assert (last_wb == {EV_T0[31:4], 4'h0})
                else stop_on_error($sformatf("MISMATCH at %0t: write-back address %08h",
                                             $time, last_wb));
                cpu_access(1'b0, EV_T0, 4'h0, 32'h0, lat);
                cpu_access(1'b0, EV_T0 ^ 32'h8, 4'h0, 32'h0, lat);

                for (int n = 0; n < N_RANDOM; n++) begin
                        wr   = lfsr_bit();
                        ti   = int'(rand_bits(2) % 3);
                        ii   = int'(rand_bits(2));
                        bits = rand_bits(6);
                        strb = bits[3:0];
                        addr = {tag_pool[ti], index_pool[ii], bits[5:4], 2'b00};
                        cpu_access(wr, addr, strb, rand_bits(32), lat);
                end

                $display("Test completed successfully");
                $finish;
        end

endmodule

// ==== build.f ====
verilog/cache_cfg_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/cache_req_if.sv
verilog/sp_ram.sv
verilog/refill_beat_counter.sv
verilog/cache_fsm.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/cache_top.sv
tb/tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
        --top-module tb_cache \
        -Mdir obj_dir \
        -f build.f
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed"
        exit $status
fi

./obj_dir/Vtb_cache
status=$?
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit $status
fi

exit 0
